// ==== logic/harness_defs.svh ====
`ifndef HARNESS_DEFS_SVH
`define HARNESS_DEFS_SVH

// Memory geometry
`define MEM_WORDS 1024

// Word index width, log2 of MEM_WORDS
`define MEM_IDX_BITS 10

// Edges of core reset after the host hold drops
`define CORE_RESET_CYCLES 16

`endif

// ==== logic/harness_pkg.sv ====
`default_nettype none

package harness_pkg;

    // Bus payload widths
    typedef logic [31:0] word_t;   // Data or instruction word
    typedef logic [31:0] addr_t;   // Byte address, low two bits zero
    typedef logic [3:0]  strb_t;   // Bit n enables byte n

    // Core reset sequencing
    typedef enum logic [1:0] {
        HOLD,    // Host keeps the core in reset
        COUNT,   // Counting down after host release
        RUN      // Core released
    } rst_state_t;

endpackage

`default_nettype wire

// ==== logic/wb_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface wb_if
    import harness_pkg::*;
();

    logic  cyc;
    logic  stb;
    logic  we;     // High for write cycles
    addr_t adr;
    strb_t sel;
    word_t dat_w;
    word_t dat_r;
    logic  ack;    // One cycle per transfer

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output sel,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  sel,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

`default_nettype wire

// ==== logic/core_reset_gen.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "harness_defs.svh"

module core_reset_gen
    import harness_pkg::*;
(
    input  logic clk_core,
    input  logic arst_n_i,
    input  logic host_hold_i,
    output logic core_rst_o
);

    localparam int CNT_W = $clog2(`CORE_RESET_CYCLES + 1);

    rst_state_t       state;
    logic [CNT_W-1:0] cnt;     // Edges left before release

    always_ff @(posedge clk_core or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state      <= HOLD;
            cnt        <= '0;
            core_rst_o <= 1'b1;
        end else if (host_hold_i) begin
            state      <= HOLD;   // Host took the core back
            cnt        <= '0;
            core_rst_o <= 1'b1;
        end else begin
            case (state)
                HOLD: begin
                    // First edge with hold low counts as one
                    state <= COUNT;
                    cnt   <= CNT_W'(`CORE_RESET_CYCLES - 1);
                end
                COUNT: begin
                    if (cnt == CNT_W'(1)) begin
                        state      <= RUN;
                        core_rst_o <= 1'b0;
                    end
                    cnt <= cnt - CNT_W'(1);
                end
                default: begin
                    state <= RUN;
                end
            endcase
        end
    end

    // Core never runs outside RUN
    a_rst_until_run: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        (state != RUN) |-> core_rst_o);

endmodule

`default_nettype wire

// ==== logic/fetch_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_bridge
    import harness_pkg::*;
(
    input  logic  clk_core,
    input  logic  arst_n_i,
    input  logic  req_valid_i,
    output logic  req_ready_o,
    input  addr_t addr_i,
    output logic  rsp_valid_o,
    input  logic  rsp_ready_i,
    output word_t instr_o,
    wb_if.master  bus
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        RESP
    } fetch_state_t;

    fetch_state_t state;
    addr_t        adr_q;   // Fetch address under way

    assign req_ready_o = (state == IDLE);
    assign rsp_valid_o = (state == RESP);

    // Read-only master, whole words
    assign bus.cyc   = (state == BUSY);
    assign bus.stb   = (state == BUSY);
    assign bus.we    = 1'b0;
    assign bus.sel   = '1;
    assign bus.adr   = adr_q;
    assign bus.dat_w = '0;

    always_ff @(posedge clk_core or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (req_valid_i) state <= BUSY;
                BUSY: if (bus.ack) state <= RESP;      // Drop stb on the ack edge
                RESP: if (rsp_ready_i) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_core) begin
        if (req_valid_i && req_ready_o) begin
            adr_q <= addr_i;
        end
        if ((state == BUSY) && bus.ack) begin
            instr_o <= bus.dat_r;   // Held through RESP
        end
    end

    a_fetch_aligned: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        (req_valid_i && req_ready_o) |-> (addr_i[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== logic/data_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_bridge
    import harness_pkg::*;
(
    input  logic  clk_core,
    input  logic  arst_n_i,
    input  logic  req_valid_i,
    output logic  req_ready_o,
    input  addr_t addr_i,
    input  strb_t wstrb_i,
    input  word_t wdata_i,
    output logic  rsp_valid_o,
    input  logic  rsp_ready_i,
    output word_t rdata_o,
    wb_if.master  bus
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        RESP
    } data_state_t;

    data_state_t state;
    addr_t       adr_q;
    logic        we_q;
    strb_t       sel_q;
    word_t       dat_w_q;
    logic        is_store;

    assign is_store = |wstrb_i;   // All-zero strobe is a load

    assign req_ready_o = (state == IDLE);
    assign rsp_valid_o = (state == RESP);

    assign bus.cyc   = (state == BUSY);
    assign bus.stb   = (state == BUSY);
    assign bus.we    = we_q;
    assign bus.sel   = sel_q;
    assign bus.adr   = adr_q;
    assign bus.dat_w = dat_w_q;

    always_ff @(posedge clk_core or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (req_valid_i) state <= BUSY;
                BUSY: if (bus.ack) state <= RESP;
                RESP: if (rsp_ready_i) state <= IDLE;   // Holds under back-pressure
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_core) begin
        if (req_valid_i && req_ready_o) begin
            adr_q   <= addr_i;
            we_q    <= is_store;
            sel_q   <= is_store ? wstrb_i : '1;   // Loads read the whole word
            dat_w_q <= wdata_i;
        end
        // Stores get the old word back
        if ((state == BUSY) && bus.ack) begin
            rdata_o <= bus.dat_r;
        end
    end

    a_adr_stable: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        (bus.stb && !bus.ack) |=> $stable(bus.adr));

endmodule

`default_nettype wire

// ==== logic/wb_dual_memory.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "harness_defs.svh"

module wb_dual_memory
    import harness_pkg::*;
(
    input  logic  clk_core,
    input  logic  arst_n_i,
    wb_if.slave   ibus,
    wb_if.slave   dbus,
    input  logic  load_valid_i,
    output logic  load_ready_o,
    input  addr_t load_addr_i,
    input  word_t load_data_i
);

    word_t mem [`MEM_WORDS];

    logic [`MEM_IDX_BITS-1:0] idx_a;
    logic [`MEM_IDX_BITS-1:0] idx_b;
    logic [`MEM_IDX_BITS-1:0] idx_ld;

    logic  ack_a;
    logic  ack_b;
    logic  req_a;      // Port A request seen for the first time
    logic  req_b;
    logic  load_fire;
    word_t dat_r_a;
    word_t dat_r_b;

    // Word index from byte address
    assign idx_a  = ibus.adr[`MEM_IDX_BITS+1:2];
    assign idx_b  = dbus.adr[`MEM_IDX_BITS+1:2];
    assign idx_ld = load_addr_i[`MEM_IDX_BITS+1:2];

    assign req_a = ibus.cyc && ibus.stb && !ack_a;
    assign req_b = dbus.cyc && dbus.stb && !ack_b;

    // Port B owns the write side until it acks
    assign load_ready_o = !(dbus.stb && !ack_b);
    assign load_fire    = load_valid_i && load_ready_o;

    assign ibus.ack   = ack_a;
    assign ibus.dat_r = dat_r_a;
    assign dbus.ack   = ack_b;
    assign dbus.dat_r = dat_r_b;

    always_ff @(posedge clk_core or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_a <= 1'b0;
            ack_b <= 1'b0;
        end else begin
            ack_a <= req_a;
            ack_b <= req_b;
        end
    end

    // Port A, instruction reads
    always_ff @(posedge clk_core) begin
        if (req_a) begin
            dat_r_a <= mem[idx_a];
        end
    end

    // Port B and host load share the write side
    always_ff @(posedge clk_core) begin
        if (req_b) begin
            dat_r_b <= mem[idx_b];   // Old word, also for stores
            if (dbus.we) begin
                for (int i = 0; i < $bits(strb_t); i++) begin
                    if (dbus.sel[i]) begin
                        mem[idx_b][8*i +: 8] <= dbus.dat_w[8*i +: 8];
                    end
                end
            end
        end else if (load_fire) begin
            mem[idx_ld] <= load_data_i;   // Always full word
        end
    end

    a_ack_a_single: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        ibus.ack |=> !ibus.ack);

    a_ack_b_single: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        dbus.ack |=> !dbus.ack);

endmodule

`default_nettype wire

// ==== logic/harness_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module harness_top
    import harness_pkg::*;
(
    input  logic  clk_core,
    input  logic  arst_n_i,

    // Core fetch port
    input  logic  fetch_req_valid_i,
    output logic  fetch_req_ready_o,
    input  addr_t fetch_addr_i,
    output logic  fetch_rsp_valid_o,
    input  logic  fetch_rsp_ready_i,
    output word_t fetch_instr_o,

    // Core data port
    input  logic  data_req_valid_i,
    output logic  data_req_ready_o,
    input  addr_t data_addr_i,
    input  strb_t data_wstrb_i,      // Zero for loads
    input  word_t data_wdata_i,
    output logic  data_rsp_valid_o,
    input  logic  data_rsp_ready_i,
    output word_t data_rdata_o,

    // Host program load
    input  logic  load_valid_i,
    output logic  load_ready_o,
    input  addr_t load_addr_i,
    input  word_t load_data_i,

    input  logic  host_hold_i,
    output logic  core_rst_o
);

    wb_if ibus ();   // Fetch bridge to port A
    wb_if dbus ();   // Data bridge to port B

    core_reset_gen u_core_reset_gen (
        .clk_core    (clk_core),
        .arst_n_i    (arst_n_i),
        .host_hold_i (host_hold_i),
        .core_rst_o  (core_rst_o)
    );

    fetch_bridge u_fetch_bridge (
        .clk_core    (clk_core),
        .arst_n_i    (arst_n_i),
        .req_valid_i (fetch_req_valid_i),
        .req_ready_o (fetch_req_ready_o),
        .addr_i      (fetch_addr_i),
        .rsp_valid_o (fetch_rsp_valid_o),
        .rsp_ready_i (fetch_rsp_ready_i),
        .instr_o     (fetch_instr_o),
        .bus         (ibus.master)
    );

    data_bridge u_data_bridge (
        .clk_core    (clk_core),
        .arst_n_i    (arst_n_i),
        .req_valid_i (data_req_valid_i),
        .req_ready_o (data_req_ready_o),
        .addr_i      (data_addr_i),
        .wstrb_i     (data_wstrb_i),
        .wdata_i     (data_wdata_i),
        .rsp_valid_o (data_rsp_valid_o),
        .rsp_ready_i (data_rsp_ready_i),
        .rdata_o     (data_rdata_o),
        .bus         (dbus.master)
    );

    wb_dual_memory u_wb_dual_memory (
        .clk_core     (clk_core),
        .arst_n_i     (arst_n_i),
        .ibus         (ibus.slave),
        .dbus         (dbus.slave),
        .load_valid_i (load_valid_i),
        .load_ready_o (load_ready_o),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i)
    );

endmodule

`default_nettype wire

// ==== verif/tb_harness.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "harness_defs.svh"

module tb_harness
    import harness_pkg::*;
();

    localparam int TEST_CYCLES = 1500;              // Rough length of all tests
    localparam int MAX_CYCLES  = TEST_CYCLES * 8 / 3;
    localparam int N_PROG      = 32;                 // Words in the loaded program

    logic  clk_core = 1'b0;
    logic  arst_n_i;
    logic  fetch_req_valid_i, fetch_req_ready_o, fetch_rsp_valid_o, fetch_rsp_ready_i;
    addr_t fetch_addr_i;
    word_t fetch_instr_o;
    logic  data_req_valid_i, data_req_ready_o, data_rsp_valid_o, data_rsp_ready_i;
    addr_t data_addr_i;
    strb_t data_wstrb_i;
    word_t data_wdata_i, data_rdata_o;
    logic  load_valid_i, load_ready_o;
    addr_t load_addr_i;
    word_t load_data_i;
    logic  host_hold_i, core_rst_o;

    word_t ref_mem [`MEM_WORDS];   // Reference memory model
    word_t exp_fetch, exp_data;
    logic  fetch_pend = 1'b0;
    logic  data_pend  = 1'b0;
    logic [`MEM_IDX_BITS-1:0] f_idx, d_idx;
    strb_t d_strb;
    word_t d_wdata;
    int    seed   = 59009;
    int    errors = 0;
    int    tests  = 0;
    int    cycles = 0;
    logic  bp_en  = 1'b0;          // Random back-pressure on responses
    string cur_test = "reset";

    harness_top dut (.*);

    always #4 clk_core = ~clk_core;

    // Random response ready under back-pressure
    always @(negedge clk_core) begin
        fetch_rsp_ready_i <= bp_en ? (($random(seed) & 3) == 0) : 1'b1;
        data_rsp_ready_i  <= bp_en ? (($random(seed) & 3) == 0) : 1'b1;
    end

    always @(posedge clk_core) begin
        cycles++;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles in test %s", cycles, cur_test);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Model reads see only writes of earlier edges
    always @(posedge clk_core) begin
        if (arst_n_i) begin
            if (fetch_pend) begin
                exp_fetch  = ref_mem[f_idx];
                fetch_pend = 1'b0;
            end
            if (data_pend) begin
                exp_data = ref_mem[d_idx];   // Old word for stores too
                for (int i = 0; i < 4; i++) begin
                    if (d_strb[i]) ref_mem[d_idx][8*i +: 8] = d_wdata[8*i +: 8];
                end
                data_pend = 1'b0;
            end
            if (load_valid_i && load_ready_o) begin
                ref_mem[load_addr_i[`MEM_IDX_BITS+1:2]] = load_data_i;
            end
            if (fetch_req_valid_i && fetch_req_ready_o) begin
                fetch_pend = 1'b1;
                f_idx      = fetch_addr_i[`MEM_IDX_BITS+1:2];
            end
            if (data_req_valid_i && data_req_ready_o) begin
                data_pend = 1'b1;
                d_idx     = data_addr_i[`MEM_IDX_BITS+1:2];
                d_strb    = data_wstrb_i;
                d_wdata   = data_wdata_i;
            end
        end
    end

    a_fetch_data: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        fetch_rsp_valid_o |-> fetch_instr_o == exp_fetch)
        else begin
            $display("Mismatch %s: fetch expected %h actual %h",
                     cur_test, exp_fetch, fetch_instr_o);
            errors++;
        end

    a_data_data: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        data_rsp_valid_o |-> data_rdata_o == exp_data)
        else begin
            $display("Mismatch %s: data expected %h actual %h",
                     cur_test, exp_data, data_rdata_o);
            errors++;
        end

    // Two-cycle request to response latency
    a_fetch_lat: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        (fetch_req_valid_i && fetch_req_ready_o) |=>
            !fetch_rsp_valid_o ##1 !fetch_rsp_valid_o ##1 fetch_rsp_valid_o)
        else begin
            $display("%s: fetch response did not come 2 cycles after acceptance", cur_test);
            errors++;
        end

    a_data_lat: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        (data_req_valid_i && data_req_ready_o) |=>
            !data_rsp_valid_o ##1 !data_rsp_valid_o ##1 data_rsp_valid_o)
        else begin
            $display("%s: data response did not come 2 cycles after acceptance", cur_test);
            errors++;
        end

    a_fetch_hold: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        (fetch_rsp_valid_o && !fetch_rsp_ready_i) |=>
            fetch_rsp_valid_o && $stable(fetch_instr_o) && !fetch_req_ready_o)
        else begin
            $display("%s: fetch response changed or a request was accepted while stalled",
                     cur_test);
            errors++;
        end

    a_data_hold: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        (data_rsp_valid_o && !data_rsp_ready_i) |=>
            data_rsp_valid_o && $stable(data_rdata_o) && !data_req_ready_o)
        else begin
            $display("%s: data response changed or a request was accepted while stalled",
                     cur_test);
            errors++;
        end

    a_rst_held: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        host_hold_i |=> core_rst_o)
        else begin
            $display("%s: core reset dropped while the host holds it", cur_test);
            errors++;
        end

    // Release exactly CORE_RESET_CYCLES edges after hold is first sampled low
    a_rst_release: assert property (@(posedge clk_core) disable iff (!arst_n_i || host_hold_i)
        $fell(host_hold_i) |-> ##(`CORE_RESET_CYCLES - 1) core_rst_o ##1 !core_rst_o)
        else begin
            $display("%s: core reset released at the wrong edge", cur_test);
            errors++;
        end

    function automatic addr_t word_addr(input int k);
        return addr_t'(((k * 37) % `MEM_WORDS) * 4);   // Spread over the whole array
    endfunction

    task automatic host_load(input addr_t addr, input word_t data);
        @(negedge clk_core);
        load_valid_i = 1'b1;
        load_addr_i  = addr;
        load_data_i  = data;
        do @(posedge clk_core); while (!load_ready_o);
        @(negedge clk_core);
        load_valid_i = 1'b0;
    endtask

    task automatic fetch_word(input addr_t addr);
        @(negedge clk_core);
        fetch_req_valid_i = 1'b1;
        fetch_addr_i      = addr;
        do @(posedge clk_core); while (!fetch_req_ready_o);
        @(negedge clk_core);
        fetch_req_valid_i = 1'b0;
        do @(posedge clk_core); while (!(fetch_rsp_valid_o && fetch_rsp_ready_i));
    endtask

    task automatic data_access(input addr_t addr, input strb_t strb, input word_t wdata);
        @(negedge clk_core);
        data_req_valid_i = 1'b1;
        data_addr_i      = addr;
        data_wstrb_i     = strb;
        data_wdata_i     = wdata;
        do @(posedge clk_core); while (!data_req_ready_o);
        @(negedge clk_core);
        data_req_valid_i = 1'b0;
        do @(posedge clk_core); while (!(data_rsp_valid_o && data_rsp_ready_i));
    endtask

    function automatic strb_t rand_strb();
        strb_t s;
        s = strb_t'($random(seed));
        if (s == '0) s = 4'b0001;
        return s;
    endfunction

    task automatic report_test(input int errs_before);
        tests++;
        $display("Test %-12s %s (%0d errors)", cur_test,
                 (errors == errs_before) ? "ok" : "failed", errors - errs_before);
    endtask

    initial begin
        int e;
        arst_n_i = 1'b0;
        host_hold_i = 1'b1;
        fetch_req_valid_i = 1'b0;
        fetch_rsp_ready_i = 1'b1;
        fetch_addr_i = '0;
        data_req_valid_i = 1'b0;
        data_rsp_ready_i = 1'b1;
        data_addr_i = '0;
        data_wstrb_i = '0;
        data_wdata_i = '0;
        load_valid_i = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        repeat (8) @(negedge clk_core);
        arst_n_i = 1'b1;

        e = errors;
        assert (core_rst_o && !fetch_rsp_valid_o && !data_rsp_valid_o
                && fetch_req_ready_o && data_req_ready_o)
        else begin
            $display("reset: outputs not in their reset state");
            errors++;
        end
        repeat (6) @(negedge clk_core);
        host_hold_i = 1'b0;
        do @(posedge clk_core); while (core_rst_o);
        report_test(e);

        cur_test = "prog_fetch";
        e = errors;
        for (int k = 0; k < N_PROG; k++) host_load(word_addr(k), word_t'($random(seed)));
        for (int k = 0; k < N_PROG; k++) fetch_word(word_addr(k));
        report_test(e);

        cur_test = "byte_store";
        e = errors;
        for (int n = 0; n < 40; n++) begin
            addr_t a;
            a = word_addr(($random(seed) & 32'h7fff_ffff) % N_PROG);
            data_access(a, rand_strb(), word_t'($random(seed)));
            data_access(a, '0, '0);   // Read back the merged word
        end
        report_test(e);

        cur_test = "backpressure";
        e = errors;
        bp_en = 1'b1;
        fork
            for (int n = 0; n < 20; n++)
                fetch_word(word_addr(($random(seed) & 32'h7fff_ffff) % N_PROG));
            for (int n = 0; n < 20; n++)
                data_access(word_addr(($random(seed) & 32'h7fff_ffff) % N_PROG),
                            (n % 2) ? rand_strb() : '0, word_t'($random(seed)));
        join
        bp_en = 1'b0;
        report_test(e);

        cur_test = "concurrent";
        e = errors;
        fork
            for (int n = 0; n < 40; n++)
                fetch_word(word_addr(($random(seed) & 32'h7fff_ffff) % N_PROG));
            for (int n = 0; n < 40; n++)
                data_access(word_addr(($random(seed) & 32'h7fff_ffff) % N_PROG),
                            (n % 3 == 0) ? '0 : rand_strb(), word_t'($random(seed)));
            for (int n = 0; n < 30; n++)
                host_load(word_addr(($random(seed) & 32'h7fff_ffff) % N_PROG),
                          word_t'($random(seed)));
        join
        // Sweep so a dropped load write shows up
        for (int k = 0; k < N_PROG; k++) fetch_word(word_addr(k));
        report_test(e);

        repeat (2) @(posedge clk_core);
        $display("Tests run: %0d, errors: %0d, cycles: %0d", tests, errors, cycles);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+logic
logic/harness_pkg.sv
logic/wb_if.sv
logic/core_reset_gen.sv
logic/fetch_bridge.sv
logic/data_bridge.sv
logic/wb_dual_memory.sv
logic/harness_top.sv
verif/tb_harness.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module tb_harness -Mdir obj_dir

run: build
	./obj_dir/Vtb_harness | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	verilator --lint-only --timing -f list.f --top-module tb_harness
	verilator --lint-only -f list.f logic/harness_top.sv --top-module harness_top

clean:
	rm -rf obj_dir $(LOG)
